//--- rtl/ecc_pkg.sv
package ecc_pkg;

    // ========================================================================
    // widths and sizes
    // ========================================================================

    // the syndrome table in the codec is only valid for 14 data and 6 check bits.
    localparam int data_width   = 14;
    localparam int parity_width = 6;
    localparam int code_width   = data_width + parity_width;
    localparam int addr_width   = 4;
    localparam int mem_depth    = 1 << addr_width;
    localparam int cnt_width    = 8;

    typedef enum logic [1:0] {
        err_none   = 2'd0,
        err_single = 2'd1,
        err_double = 2'd2
    } err_kind_e;

    // ========================================================================
    // check-bit encoder
    // ========================================================================

    // each check bit covers the data bits whose syndrome column has that bit set.
    // every column has odd weight of three or more, so a double flip never looks
    // like a single one.
    function automatic logic [parity_width-1:0] ecc_check_bits(
        input logic [data_width-1:0] d
    );
        logic [parity_width-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10];
        p[4] = d[11] ^ d[12] ^ d[13];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12];
        return p;
    endfunction

endpackage

//--- rtl/ecc_14_codec.sv
module ecc_14_codec (
    input  logic [ecc_pkg::data_width-1:0]   code_data,
    input  logic [ecc_pkg::parity_width-1:0] code_parity,
    input  logic                             bypass,
    output logic [ecc_pkg::data_width-1:0]   fixed_data,
    output ecc_pkg::err_kind_e               err_kind
);

    logic [ecc_pkg::parity_width-1:0] syndrome;
    logic [ecc_pkg::data_width-1:0]   flip;
    ecc_pkg::err_kind_e               kind;

    assign syndrome = code_parity ^ ecc_pkg::ecc_check_bits(code_data);

    // ========================================================================
    // syndrome decode
    // ========================================================================

    always_comb begin
        flip = '0;
        kind = ecc_pkg::err_single;
        case (syndrome)
            6'b000000: kind = ecc_pkg::err_none;
            // one column per data bit, bit 0 first.
            6'b100011: flip[0]  = 1'b1;
            6'b100101: flip[1]  = 1'b1;
            6'b100110: flip[2]  = 1'b1;
            6'b000111: flip[3]  = 1'b1;
            6'b101001: flip[4]  = 1'b1;
            6'b101010: flip[5]  = 1'b1;
            6'b001011: flip[6]  = 1'b1;
            6'b101100: flip[7]  = 1'b1;
            6'b001101: flip[8]  = 1'b1;
            6'b001110: flip[9]  = 1'b1;
            6'b101111: flip[10] = 1'b1;
            6'b110001: flip[11] = 1'b1;
            6'b110010: flip[12] = 1'b1;
            6'b010011: flip[13] = 1'b1;
            // a one-hot syndrome is a flipped check bit, the data is fine.
            6'b100000,
            6'b010000,
            6'b001000,
            6'b000100,
            6'b000010,
            6'b000001: kind = ecc_pkg::err_single;
            default:   kind = ecc_pkg::err_double;
        endcase
    end

    assign fixed_data = bypass ? code_data : (code_data ^ flip);
    assign err_kind   = bypass ? ecc_pkg::err_none : kind;

    // a known codeword must always decode to a known result, and a corrected
    // single error leaves at most one flipped check bit behind.
    a_kind_known: assert final (
        $isunknown({code_data, code_parity, bypass}) ||
        (!$isunknown(err_kind) && ((err_kind != ecc_pkg::err_single) ||
         $onehot0(code_parity ^ ecc_pkg::ecc_check_bits(fixed_data))))
    );

endmodule

//--- rtl/ecc_mem_array.sv
module ecc_mem_array (
    input  logic                           clk,
    input  logic                           mem_we,
    input  logic [ecc_pkg::addr_width-1:0] mem_waddr,
    input  logic [ecc_pkg::code_width-1:0] mem_wcode,
    input  logic                           mem_re,
    input  logic [ecc_pkg::addr_width-1:0] mem_raddr,
    output logic [ecc_pkg::code_width-1:0] mem_rcode
);

    logic [ecc_pkg::code_width-1:0] mem [ecc_pkg::mem_depth];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wcode;
        end
    end

    // the read register holds its value until the next read.
    // a write to the same address at the same edge is not seen.
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rcode <= mem[mem_raddr];
        end
    end

endmodule

//--- rtl/ecc_mem_ctrl.sv
module ecc_mem_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [ecc_pkg::addr_width-1:0]   wr_addr,
    input  logic [ecc_pkg::data_width-1:0]   wr_data,
    input  logic [ecc_pkg::code_width-1:0]   inject_mask,
    input  logic                             rd_en,
    input  logic [ecc_pkg::addr_width-1:0]   rd_addr,
    input  logic                             bypass,
    input  logic [ecc_pkg::code_width-1:0]   mem_rcode,
    input  logic [ecc_pkg::data_width-1:0]   fixed_data,
    input  ecc_pkg::err_kind_e               err_kind,
    output logic                             mem_we,
    output logic [ecc_pkg::addr_width-1:0]   mem_waddr,
    output logic [ecc_pkg::code_width-1:0]   mem_wcode,
    output logic                             mem_re,
    output logic [ecc_pkg::addr_width-1:0]   mem_raddr,
    output logic [ecc_pkg::data_width-1:0]   code_data,
    output logic [ecc_pkg::parity_width-1:0] code_parity,
    output logic                             code_bypass,
    output logic                             rd_valid,
    output logic [ecc_pkg::data_width-1:0]   rd_data,
    output ecc_pkg::err_kind_e               rd_err,
    output logic                             log_evt,
    output ecc_pkg::err_kind_e               log_kind,
    output logic [ecc_pkg::addr_width-1:0]   log_addr
);

    logic                           byp1;
    logic                           rd_v2;
    logic [ecc_pkg::addr_width-1:0] addr2;
    logic                           byp2;
    logic                           wr_hit2;
    logic                           scrub_ok;
    logic                           scrub_pend;
    logic [ecc_pkg::addr_width-1:0] scrub_addr;
    logic [ecc_pkg::code_width-1:0] scrub_code;
    logic [ecc_pkg::code_width-1:0] wr_code;

    // ========================================================================
    // write port arbitration
    // ========================================================================

    assign wr_code = {ecc_pkg::ecc_check_bits(wr_data), wr_data} ^ inject_mask;

    // an external write always wins over a pending scrub.
    assign mem_we    = wr_en || scrub_pend;
    assign mem_waddr = wr_en ? wr_addr : scrub_addr;
    assign mem_wcode = wr_en ? wr_code : scrub_code;

    // ========================================================================
    // read pipeline
    // ========================================================================

    assign code_data   = mem_rcode[ecc_pkg::data_width-1:0];
    assign code_parity = mem_rcode[ecc_pkg::code_width-1:ecc_pkg::data_width];
    assign code_bypass = byp2;

    // a scrub is dropped if the address was written after the array read it,
    // since the corrected word would then overwrite newer data.
    assign scrub_ok = rd_v2 && (err_kind == ecc_pkg::err_single) && !byp2 &&
                      !wr_hit2 && !(wr_en && (wr_addr == addr2));

    assign log_evt  = rd_valid;
    assign log_kind = rd_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_re     <= 1'b0;
            rd_v2      <= 1'b0;
            rd_valid   <= 1'b0;
            scrub_pend <= 1'b0;
        end else begin
            mem_re     <= rd_en;
            rd_v2      <= mem_re;
            rd_valid   <= rd_v2;
            scrub_pend <= scrub_ok;
        end
    end

    always_ff @(posedge clk) begin
        mem_raddr  <= rd_addr;
        byp1       <= bypass;
        addr2      <= mem_raddr;
        byp2       <= byp1;
        wr_hit2    <= wr_en && (wr_addr == mem_raddr);
        rd_data    <= fixed_data;
        rd_err     <= err_kind;
        log_addr   <= addr2;
        scrub_addr <= addr2;
        scrub_code <= {ecc_pkg::ecc_check_bits(fixed_data), fixed_data};
    end

    // the bypass level is taken when the read is issued, three edges before
    // the result is sampled here.
    a_bypass_no_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && (rd_err == ecc_pkg::err_single) |-> !$past(bypass, 3));

    // a write-back without wr_en comes from the single-error result shown in
    // the same cycle, at the address that result reported.
    a_scrub_source: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we && !wr_en |-> rd_valid && (rd_err == ecc_pkg::err_single) &&
                             (mem_waddr == log_addr));

endmodule

//--- rtl/ecc_err_log.sv
module ecc_err_log (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           log_clr,
    input  logic                           log_evt,
    input  ecc_pkg::err_kind_e             log_kind,
    input  logic [ecc_pkg::addr_width-1:0] log_addr,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] dbit_addr,
    output logic                           dbit_seen
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = log_evt && (log_kind == ecc_pkg::err_single);
    assign dbit_hit = log_evt && (log_kind == ecc_pkg::err_double);

    // clear wins over an event at the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
            dbit_seen  <= 1'b0;
        end else if (log_clr) begin
            sbit_count <= '0;
            dbit_count <= '0;
            dbit_seen  <= 1'b0;
        end else begin
            if (sbit_hit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_hit && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (dbit_hit) begin
                dbit_seen <= 1'b1;
            end
        end
    end

    // only the first double error after a clear is kept.
    always_ff @(posedge clk) begin
        if (dbit_hit && !dbit_seen && !log_clr) begin
            dbit_addr <= log_addr;
        end
    end

    a_sbit_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (sbit_count == '1) && !log_clr |=> (sbit_count == '1));

    a_dbit_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (dbit_count == '1) && !log_clr |=> (dbit_count == '1));

endmodule

//--- rtl/ecc_mem_top.sv
module ecc_mem_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [ecc_pkg::addr_width-1:0] wr_addr,
    input  logic [ecc_pkg::data_width-1:0] wr_data,
    input  logic [ecc_pkg::code_width-1:0] inject_mask,
    input  logic                           rd_en,
    input  logic [ecc_pkg::addr_width-1:0] rd_addr,
    input  logic                           bypass,
    input  logic                           log_clr,
    output logic                           rd_valid,
    output logic [ecc_pkg::data_width-1:0] rd_data,
    output ecc_pkg::err_kind_e             rd_err,
    output logic [ecc_pkg::cnt_width-1:0]  sbit_count,
    output logic [ecc_pkg::cnt_width-1:0]  dbit_count,
    output logic [ecc_pkg::addr_width-1:0] dbit_addr,
    output logic                           dbit_seen
);

    logic                             mem_we;
    logic [ecc_pkg::addr_width-1:0]   mem_waddr;
    logic [ecc_pkg::code_width-1:0]   mem_wcode;
    logic                             mem_re;
    logic [ecc_pkg::addr_width-1:0]   mem_raddr;
    logic [ecc_pkg::code_width-1:0]   mem_rcode;
    logic [ecc_pkg::data_width-1:0]   code_data;
    logic [ecc_pkg::parity_width-1:0] code_parity;
    logic                             code_bypass;
    logic [ecc_pkg::data_width-1:0]   fixed_data;
    ecc_pkg::err_kind_e               err_kind;
    logic                             log_evt;
    ecc_pkg::err_kind_e               log_kind;
    logic [ecc_pkg::addr_width-1:0]   log_addr;

    ecc_mem_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .inject_mask (inject_mask),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .bypass      (bypass),
        .mem_rcode   (mem_rcode),
        .fixed_data  (fixed_data),
        .err_kind    (err_kind),
        .mem_we      (mem_we),
        .mem_waddr   (mem_waddr),
        .mem_wcode   (mem_wcode),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr),
        .code_data   (code_data),
        .code_parity (code_parity),
        .code_bypass (code_bypass),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_err      (rd_err),
        .log_evt     (log_evt),
        .log_kind    (log_kind),
        .log_addr    (log_addr)
    );

    ecc_mem_array u_array (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wcode (mem_wcode),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rcode (mem_rcode)
    );

    ecc_14_codec u_codec (
        .code_data   (code_data),
        .code_parity (code_parity),
        .bypass      (code_bypass),
        .fixed_data  (fixed_data),
        .err_kind    (err_kind)
    );

    ecc_err_log u_log (
        .clk        (clk),
        .rst_n      (rst_n),
        .log_clr    (log_clr),
        .log_evt    (log_evt),
        .log_kind   (log_kind),
        .log_addr   (log_addr),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count),
        .dbit_addr  (dbit_addr),
        .dbit_seen  (dbit_seen)
    );

endmodule

//--- tests/tb_ecc_mem.sv
module tb_ecc_mem;

    typedef logic [ecc_pkg::data_width-1:0] data_t;
    typedef logic [ecc_pkg::code_width-1:0] code_t;
    typedef logic [ecc_pkg::addr_width-1:0] addr_t;
    typedef logic [ecc_pkg::cnt_width-1:0]  cnt_t;

    // one read in flight inside the model pipeline.
    typedef struct packed {
        logic  v;
        addr_t addr;
        logic  byp;
        logic  hit;
        code_t code;
    } stage_t;

    logic               clk;
    logic               rst_n       = 1'b0;
    logic               wr_en       = 1'b0;
    addr_t              wr_addr     = '0;
    data_t              wr_data     = '0;
    code_t              inject_mask = '0;
    logic               rd_en       = 1'b0;
    addr_t              rd_addr     = '0;
    logic               bypass      = 1'b0;
    logic               log_clr     = 1'b0;
    logic               rd_valid;
    data_t              rd_data;
    ecc_pkg::err_kind_e rd_err;
    cnt_t               sbit_count;
    cnt_t               dbit_count;
    addr_t              dbit_addr;
    logic               dbit_seen;

    // syndrome column of each data bit, bit 0 first.
    logic [ecc_pkg::parity_width-1:0] cols [ecc_pkg::data_width] = '{
        6'h23, 6'h25, 6'h26, 6'h07, 6'h29, 6'h2a, 6'h0b,
        6'h2c, 6'h0d, 6'h0e, 6'h2f, 6'h31, 6'h32, 6'h13};

    code_t              m_mem [ecc_pkg::mem_depth];
    stage_t             s1 = '{1'b0, '0, 1'b0, 1'b0, '0};
    stage_t             s2 = '{1'b0, '0, 1'b0, 1'b0, '0};
    logic               res_v = 1'b0;
    data_t              res_data;
    ecc_pkg::err_kind_e res_kind;
    addr_t              res_addr;
    logic               scrub_pend = 1'b0;
    addr_t              scrub_addr;
    code_t              scrub_code;
    cnt_t               m_sbit = '0;
    cnt_t               m_dbit = '0;
    logic               m_dseen = 1'b0;
    addr_t              m_daddr;
    logic [31:0]        rng = 32'd31381;
    string              test_name;
    logic               got_result;
    data_t              got_data;
    ecc_pkg::err_kind_e got_kind;

    ecc_mem_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return int'(rng % n);
    endfunction

    function automatic code_t one_hot(input int pos);
        code_t m;
        m = '0;
        m[pos] = 1'b1;
        return m;
    endfunction

    // ========================================================================
    // reference model
    // ========================================================================

    // each set data bit adds its column into the check bits.
    function automatic code_t encode(input data_t d);
        logic [ecc_pkg::parity_width-1:0] p;
        p = '0;
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            if (d[i]) begin
                p = p ^ cols[i];
            end
        end
        return {p, d};
    endfunction

    function automatic void decode(input code_t code, input logic byp,
                                   output data_t d, output ecc_pkg::err_kind_e k);
        logic [ecc_pkg::parity_width-1:0] syn;
        code_t                            diff;
        diff = code ^ encode(code[ecc_pkg::data_width-1:0]);
        syn  = diff[ecc_pkg::code_width-1:ecc_pkg::data_width];
        d    = code[ecc_pkg::data_width-1:0];
        k    = ecc_pkg::err_double;
        if (byp || syn == '0) begin
            k = ecc_pkg::err_none;
        end else if ($countones(syn) == 1) begin
            k = ecc_pkg::err_single;
        end
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            if (!byp && syn == cols[i]) begin
                d[i] = ~d[i];
                k    = ecc_pkg::err_single;
            end
        end
    endfunction

    // advances the model by one clock edge, given the inputs sampled there.
    function automatic void model_edge(input logic we, input addr_t wa, input code_t wc,
                                       input logic re, input addr_t ra, input logic byp,
                                       input logic clr);
        data_t              d;
        ecc_pkg::err_kind_e k;
        logic               scrub_next;
        if (clr) begin
            m_sbit  = '0;
            m_dbit  = '0;
            m_dseen = 1'b0;
        end else if (res_v && res_kind == ecc_pkg::err_single && m_sbit != '1) begin
            m_sbit = m_sbit + 1'b1;
        end else if (res_v && res_kind == ecc_pkg::err_double) begin
            if (m_dbit != '1) begin
                m_dbit = m_dbit + 1'b1;
            end
            if (!m_dseen) begin
                m_daddr = res_addr;
            end
            m_dseen = 1'b1;
        end
        decode(s2.code, s2.byp, d, k);
        // a write to the address since the array read it makes the scrub stale.
        scrub_next = s2.v && k == ecc_pkg::err_single && !s2.byp && !s2.hit &&
                     !(we && wa == s2.addr);
        res_v    = s2.v;
        res_data = d;
        res_kind = k;
        res_addr = s2.addr;
        s2       = s1;
        s2.code  = m_mem[s1.addr];
        s2.hit   = we && wa == s1.addr;
        s1       = '{re, ra, byp, 1'b0, '0};
        if (we) begin
            m_mem[wa] = wc;
        end else if (scrub_pend) begin
            m_mem[scrub_addr] = scrub_code;
        end
        scrub_pend = scrub_next;
        scrub_addr = res_addr;
        scrub_code = encode(d);
    endfunction

    // ========================================================================
    // checks
    // ========================================================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s %s expected %h actual %h",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_kind(input string what, input ecc_pkg::err_kind_e exp,
                              input ecc_pkg::err_kind_e act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s %s expected %0d actual %0d",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input cnt_t exp, input cnt_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s %s expected %0d actual %0d",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s %s expected %0d actual %0d",
                                     test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s %s expected %b actual %b",
                                     test_name, what, exp, act));
        end
    endtask

    // drives one cycle, then compares the DUT with the model before the next edge.
    task automatic run_cycle(input logic we, input addr_t wa, input data_t wd, input code_t mask,
                             input logic re, input addr_t ra, input logic byp, input logic clr);
        @(posedge clk);
        wr_en       <= we;
        wr_addr     <= wa;
        wr_data     <= wd;
        inject_mask <= mask;
        rd_en       <= re;
        rd_addr     <= ra;
        bypass      <= byp;
        log_clr     <= clr;
        @(negedge clk);
        check_flag("rd_valid", res_v, rd_valid);
        if (res_v) begin
            check_data("rd_data", res_data, rd_data);
            check_kind("rd_err", res_kind, rd_err);
            got_result = 1'b1;
            got_data   = rd_data;
            got_kind   = rd_err;
        end
        check_count("sbit_count", m_sbit, sbit_count);
        check_count("dbit_count", m_dbit, dbit_count);
        check_flag("dbit_seen", m_dseen, dbit_seen);
        if (m_dseen) begin
            check_addr("dbit_addr", m_daddr, dbit_addr);
        end
        model_edge(we, wa, encode(wd) ^ mask, re, ra, byp, clr);
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic write_word(input addr_t a, input data_t d, input code_t mask);
        run_cycle(1'b1, a, d, mask, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic read_word(input addr_t a, input logic byp);
        int waited;
        got_result = 1'b0;
        run_cycle(1'b0, '0, '0, '0, 1'b1, a, byp, 1'b0);
        waited = 0;
        while (!got_result && waited < 10) begin
            idle_cycle();
            waited++;
        end
        if (!got_result) begin
            report_failure($sformatf("read of address %0d in %s gave no result within 10 cycles",
                                     a, test_name));
        end
    endtask

    // ========================================================================
    // tests
    // ========================================================================

    initial begin
        data_t data_of [ecc_pkg::mem_depth];
        code_t mask;
        int    a;
        int    b;
        int    pos;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "clean_data";
        for (int i = 0; i < ecc_pkg::mem_depth; i++) begin
            data_of[i] = data_t'(rand_below(1 << ecc_pkg::data_width));
            write_word(i, data_of[i], '0);
        end
        for (int i = 0; i < ecc_pkg::mem_depth; i++) begin
            read_word(i, 1'b0);
            check_data("rd_data", data_of[i], got_data);
            check_kind("rd_err", ecc_pkg::err_none, got_kind);
        end
        check_count("sbit_count", '0, sbit_count);
        check_count("dbit_count", '0, dbit_count);

        test_name = "single_data_bit";
        a = rand_below(ecc_pkg::mem_depth);
        write_word(a, data_of[a], one_hot(rand_below(ecc_pkg::data_width)));
        read_word(a, 1'b0);
        check_data("rd_data", data_of[a], got_data);
        check_kind("rd_err", ecc_pkg::err_single, got_kind);
        read_word(a, 1'b0);
        check_kind("rd_err after scrub", ecc_pkg::err_none, got_kind);

        test_name = "single_check_bit";
        a = rand_below(ecc_pkg::mem_depth);
        write_word(a, data_of[a], one_hot(ecc_pkg::data_width +
                                          rand_below(ecc_pkg::parity_width)));
        read_word(a, 1'b0);
        check_data("rd_data", data_of[a], got_data);
        check_kind("rd_err", ecc_pkg::err_single, got_kind);

        test_name = "double_fault";
        a    = rand_below(ecc_pkg::mem_depth);
        b    = (a + 1 + rand_below(ecc_pkg::mem_depth - 1)) % ecc_pkg::mem_depth;
        pos  = rand_below(ecc_pkg::code_width);
        mask = one_hot(pos) | one_hot((pos + 1 + rand_below(19)) % ecc_pkg::code_width);
        write_word(a, data_of[a], mask);
        write_word(b, data_of[b], mask);
        read_word(a, 1'b0);
        check_data("rd_data", data_of[a] ^ mask[ecc_pkg::data_width-1:0], got_data);
        check_kind("rd_err", ecc_pkg::err_double, got_kind);
        read_word(b, 1'b0);
        check_kind("rd_err", ecc_pkg::err_double, got_kind);
        idle_cycle();
        check_addr("dbit_addr", a, dbit_addr);

        test_name = "bypass";
        a    = rand_below(ecc_pkg::mem_depth);
        mask = one_hot(rand_below(ecc_pkg::data_width));
        write_word(a, data_of[a], mask);
        read_word(a, 1'b1);
        check_data("rd_data", data_of[a] ^ mask[ecc_pkg::data_width-1:0], got_data);
        check_kind("rd_err", ecc_pkg::err_none, got_kind);
        read_word(a, 1'b0);
        check_data("rd_data", data_of[a], got_data);
        check_kind("rd_err", ecc_pkg::err_single, got_kind);

        // clean, single and double faults mixed, with reads and writes every cycle.
        test_name = "random_traffic";
        for (int i = 0; i < 400; i++) begin
            pos  = rand_below(4);
            mask = '0;
            if (pos >= 2) begin
                mask = one_hot(rand_below(ecc_pkg::code_width));
            end
            if (pos == 3) begin
                mask = mask | one_hot(rand_below(ecc_pkg::code_width));
            end
            run_cycle(rand_below(2), rand_below(ecc_pkg::mem_depth),
                      rand_below(1 << ecc_pkg::data_width), mask, rand_below(2),
                      rand_below(ecc_pkg::mem_depth), rand_below(4) == 0, 1'b0);
        end
        repeat (4) idle_cycle();

        test_name = "log_clear";
        run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
        idle_cycle();
        check_count("sbit_count", '0, sbit_count);
        check_count("dbit_count", '0, dbit_count);
        check_flag("dbit_seen", 1'b0, dbit_seen);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sources.f
rtl/ecc_pkg.sv
rtl/ecc_14_codec.sv
rtl/ecc_mem_array.sv
rtl/ecc_mem_ctrl.sv
rtl/ecc_err_log.sv
rtl/ecc_mem_top.sv
tests/tb_ecc_mem.sv
